// ==== sat_engine_cfg.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes of one formula bin for the DPLL engine
// included by the package, every unit and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SAT_ENGINE_CFG_SVH
`define SAT_ENGINE_CFG_SVH

`define SAT_NUM_VARS    8
`define SAT_VAR_W       3   // index bits for SAT_NUM_VARS
`define SAT_NUM_CLAUSES 16
`define SAT_CLS_W       4
`define SAT_LVL_W       4   // must hold levels 0 to SAT_NUM_VARS

`endif

// ==== sat_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// literal, clause and trail types shared by the DPLL units
// plus the state encodings of the controller and the BCP scanner
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "sat_engine_cfg.svh"

package sat_pkg;

    typedef struct packed {
        logic                  en;
        logic                  neg;       // literal is true when value differs from this bit
        logic [`SAT_VAR_W-1:0] var_idx;
    } lit_t;

    typedef struct packed {
        lit_t [2:0] lit;                  // no enabled literal means the slot is inactive
    } clause_t;

    typedef struct packed {
        logic                  assigned;
        logic                  value;
        logic [`SAT_LVL_W-1:0] level;
        logic                  is_decision;
        logic                  flipped;   // decision already tried both ways
    } var_state_t;

    typedef var_state_t [`SAT_NUM_VARS-1:0] var_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        BCP,
        DECISION,
        ANALYSIS,
        BKT_CUR_BIN,
        PARTIAL_SAT,
        PARTIAL_UNSAT
    } core_state_e;

    typedef enum logic [1:0] {
        IMP_IDLE,
        IMP_SCAN,
        IMP_DONE
    } imply_state_e;

endpackage

`default_nettype wire

// ==== sat_assign_store.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assignment trail of the bin and the current decision level
// written by BCP, decision and backtrack, one writer per cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module sat_assign_store
    import sat_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  imp_we_i,
    input  logic [`SAT_VAR_W-1:0] imp_var_i,
    input  logic                  imp_val_i,
    input  logic                  dec_we_i,
    input  logic [`SAT_VAR_W-1:0] dec_var_i,
    input  logic                  bkt_we_i,
    input  logic [`SAT_VAR_W-1:0] bkt_var_i,
    input  logic [`SAT_LVL_W-1:0] bkt_lvl_i,
    output var_vec_t              vars_o,
    output logic [`SAT_LVL_W-1:0] cur_lvl_o
);

    logic [`SAT_LVL_W-1:0] next_lvl;

    assign next_lvl = cur_lvl_o + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            vars_o    <= '0;
            cur_lvl_o <= '0;
        end
        else if (imp_we_i)
        begin
            vars_o[imp_var_i] <= '{assigned: 1'b1, value: imp_val_i, level: cur_lvl_o,
                                   is_decision: 1'b0, flipped: 1'b0};
        end
        else if (dec_we_i)
        begin
            vars_o[dec_var_i] <= '{assigned: 1'b1, value: 1'b0, level: next_lvl,
                                   is_decision: 1'b1, flipped: 1'b0};
            cur_lvl_o         <= next_lvl;
        end
        else if (bkt_we_i)
        begin
            // a backtrack to level 0 has no target and empties the whole trail
            for (int i = 0; i < `SAT_NUM_VARS; i++)
            begin
                if (i == int'(bkt_var_i) && bkt_lvl_i != '0)
                begin
                    vars_o[i].value   <= ~vars_o[i].value;
                    vars_o[i].flipped <= 1'b1;
                end
                else if (vars_o[i].level >= bkt_lvl_i)
                    vars_o[i] <= '0;
            end
            cur_lvl_o <= bkt_lvl_i;
        end
    end

    a_one_writer: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({imp_we_i, dec_we_i, bkt_we_i}));

    a_lvl_bound: assert property (@(posedge clk) disable iff (!rst)
        cur_lvl_o <= `SAT_NUM_VARS);

endmodule

`default_nettype wire

// ==== sat_imply.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clause memory and BCP scanner, one clause per cycle
// a pass with any implied assignment is repeated
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module sat_imply
    import sat_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_we_i,
    input  logic [`SAT_CLS_W-1:0] load_addr_i,
    input  clause_t               load_clause_i,
    input  logic                  apply_i,
    input  var_vec_t              vars_i,
    output logic                  imp_we_o,
    output logic [`SAT_VAR_W-1:0] imp_var_o,
    output logic                  imp_val_o,
    output logic                  done_o,
    output logic                  conflict_o,
    output logic                  all_sat_o
);

    clause_t               mem [`SAT_NUM_CLAUSES];
    imply_state_e          state;
    logic [`SAT_CLS_W-1:0] idx;
    logic                  apply_q;
    logic                  changed;     // this pass assigned something
    logic                  sat_acc;
    clause_t               cls;
    logic                  active;
    logic                  has_true;
    logic [1:0]            n_free;
    logic                  is_conflict;
    logic                  is_unit;
    logic                  cls_sat;

    always_ff @(posedge clk)
    begin
        if (load_we_i)
            mem[load_addr_i] <= load_clause_i;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // classify the clause under the scan pointer
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        cls       = mem[idx];
        active    = 1'b0;
        has_true  = 1'b0;
        n_free    = '0;
        imp_var_o = cls.lit[0].var_idx;
        imp_val_o = ~cls.lit[0].neg;
        for (int k = 0; k < 3; k++)
        begin
            if (cls.lit[k].en)
            begin
                active = 1'b1;
                if (!vars_i[cls.lit[k].var_idx].assigned)
                begin
                    n_free    = n_free + 1'b1;
                    imp_var_o = cls.lit[k].var_idx;   // only taken when it is the single free one
                    imp_val_o = ~cls.lit[k].neg;
                end
                else if (vars_i[cls.lit[k].var_idx].value != cls.lit[k].neg)
                    has_true = 1'b1;
            end
        end
        is_conflict = active && !has_true && n_free == 2'd0;
        is_unit     = active && !has_true && n_free == 2'd1;
        cls_sat     = has_true || !active;
    end

    assign imp_we_o = state == IMP_SCAN && is_unit;
    assign done_o   = state == IMP_DONE;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state      <= IMP_IDLE;
            idx        <= '0;
            apply_q    <= 1'b0;
            changed    <= 1'b0;
            sat_acc    <= 1'b0;
            conflict_o <= 1'b0;
            all_sat_o  <= 1'b0;
        end
        else
        begin
            apply_q <= apply_i;
            case (state)
                IMP_IDLE:
                    if (apply_i && !apply_q)
                    begin
                        state   <= IMP_SCAN;
                        idx     <= '0;
                        changed <= 1'b0;
                        sat_acc <= 1'b1;
                    end
                IMP_SCAN:
                    if (is_conflict)
                    begin
                        state      <= IMP_DONE;
                        conflict_o <= 1'b1;
                        all_sat_o  <= 1'b0;
                    end
                    else if (idx == `SAT_CLS_W'(`SAT_NUM_CLAUSES - 1))
                    begin
                        if (changed || is_unit)   // trail moved, scan again
                        begin
                            idx     <= '0;
                            changed <= 1'b0;
                            sat_acc <= 1'b1;
                        end
                        else
                        begin
                            state      <= IMP_DONE;
                            conflict_o <= 1'b0;
                            all_sat_o  <= sat_acc && cls_sat;
                        end
                    end
                    else
                    begin
                        idx     <= idx + 1'b1;
                        changed <= changed || is_unit;
                        sat_acc <= sat_acc && cls_sat;
                    end
                default:
                    state <= IMP_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== sat_decide.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decision unit, picks the lowest unassigned variable
// and writes it as false on a new level two cycles after start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module sat_decide
    import sat_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_i,
    input  var_vec_t              vars_i,
    output logic                  dec_we_o,
    output logic [`SAT_VAR_W-1:0] dec_var_o,
    output logic                  done_o
);

    logic [`SAT_VAR_W-1:0] pick;
    logic                  any_free;
    logic                  pend_q;

    always_comb
    begin
        pick     = '0;
        any_free = 1'b0;
        for (int i = `SAT_NUM_VARS - 1; i >= 0; i--)   // downward so the lowest wins
        begin
            if (!vars_i[i].assigned)
            begin
                pick     = `SAT_VAR_W'(i);
                any_free = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_i)
            dec_var_o <= pick;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            pend_q   <= 1'b0;
            dec_we_o <= 1'b0;
        end
        else
        begin
            pend_q   <= start_i;
            dec_we_o <= pend_q;
        end
    end

    assign done_o = dec_we_o;   // the write and the done pulse share a cycle

    // BCP ended with neither conflict nor all-sat, so some variable is still open
    a_free_var: assert property (@(posedge clk) disable iff (!rst)
        start_i |-> any_free);

endmodule

`default_nettype wire

// ==== sat_backtrack.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// conflict analysis and chronological backtrack
// finds the newest unflipped decision and issues one backtrack write
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module sat_backtrack
    import sat_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  apply_analyze_i,
    input  logic                  apply_bkt_i,
    input  var_vec_t              vars_i,
    output logic                  done_analyze_o,
    output logic                  bkt_found_o,
    output logic                  done_bkt_o,
    output logic                  bkt_we_o,
    output logic [`SAT_VAR_W-1:0] bkt_var_o,
    output logic [`SAT_LVL_W-1:0] bkt_lvl_o
);

    logic                  analyze_q;
    logic                  bkt_q;
    logic                  analyze_rise;
    logic                  found;
    logic [`SAT_VAR_W-1:0] best_var;
    logic [`SAT_LVL_W-1:0] best_lvl;

    assign analyze_rise = apply_analyze_i && !analyze_q;

    always_comb
    begin
        found    = 1'b0;
        best_var = '0;
        best_lvl = '0;
        for (int i = 0; i < `SAT_NUM_VARS; i++)
        begin
            if (vars_i[i].assigned && vars_i[i].is_decision && !vars_i[i].flipped
                && vars_i[i].level > best_lvl)
            begin
                found    = 1'b1;
                best_var = `SAT_VAR_W'(i);
                best_lvl = vars_i[i].level;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (analyze_rise)
        begin
            bkt_var_o <= best_var;
            bkt_lvl_o <= best_lvl;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            analyze_q      <= 1'b0;
            bkt_q          <= 1'b0;
            done_analyze_o <= 1'b0;
            bkt_found_o    <= 1'b0;
            bkt_we_o       <= 1'b0;
        end
        else
        begin
            analyze_q      <= apply_analyze_i;
            bkt_q          <= apply_bkt_i;
            done_analyze_o <= analyze_rise;
            bkt_we_o       <= apply_bkt_i && !bkt_q;   // apply_bkt stays up two cycles
            if (analyze_rise)
                bkt_found_o <= found;
        end
    end

    assign done_bkt_o = bkt_we_o;

    // the controller only asks for a backtrack after analysis found a target
    a_bkt_has_target: assert property (@(posedge clk) disable iff (!rst)
        bkt_we_o |-> bkt_found_o);

endmodule

`default_nettype wire

// ==== ctrl_core.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencing FSM of the engine, alternates BCP and decision,
// runs analysis and backtrack on conflict, and holds the verdict
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module ctrl_core
    import sat_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start_core_i,
    input  logic done_imply_i,
    input  logic conflict_i,
    input  logic all_c_is_sat_i,
    input  logic done_decision_i,
    input  logic done_analyze_i,
    input  logic bkt_found_i,
    input  logic done_bkt_cur_bin_i,
    output logic done_core_o,
    output logic apply_imply_o,
    output logic start_decision_o,
    output logic apply_analyze_o,
    output logic apply_bkt_cur_bin_o,
    output logic sat_o,
    output logic unsat_o
);

    core_state_e c_state;
    core_state_e n_state;

    always_ff @(posedge clk)
    begin
        if (!rst)
            c_state <= IDLE;
        else
            c_state <= n_state;
    end

    always_comb
    begin
        n_state = c_state;
        case (c_state)
            IDLE:
                if (start_core_i)
                    n_state = BCP;
            BCP:
                if (done_imply_i)
                    n_state = conflict_i ? ANALYSIS : (all_c_is_sat_i ? PARTIAL_SAT : DECISION);
            DECISION:
                if (done_decision_i)
                    n_state = BCP;
            ANALYSIS:
                if (done_analyze_i)
                    n_state = bkt_found_i ? BKT_CUR_BIN : PARTIAL_UNSAT;   // nothing left to flip
            BKT_CUR_BIN:
                if (done_bkt_cur_bin_i)
                    n_state = BCP;
            default:
                n_state = IDLE;   // both verdict states last one cycle
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            apply_imply_o       <= 1'b0;
            apply_analyze_o     <= 1'b0;
            apply_bkt_cur_bin_o <= 1'b0;
            start_decision_o    <= 1'b0;
            done_core_o         <= 1'b0;
            sat_o               <= 1'b0;
            unsat_o             <= 1'b0;
        end
        else
        begin
            apply_imply_o       <= c_state == BCP;
            apply_analyze_o     <= c_state == ANALYSIS;
            apply_bkt_cur_bin_o <= c_state == BKT_CUR_BIN && !done_bkt_cur_bin_i;
            start_decision_o    <= n_state == DECISION && c_state != DECISION;
            done_core_o         <= c_state == PARTIAL_SAT || c_state == PARTIAL_UNSAT;
            if (n_state == PARTIAL_SAT)   // verdict leads done_core_o by one cycle
            begin
                sat_o   <= 1'b1;
                unsat_o <= 1'b0;
            end
            else if (n_state == PARTIAL_UNSAT)
            begin
                sat_o   <= 1'b0;
                unsat_o <= 1'b1;
            end
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_core_o |=> !done_core_o);

endmodule

`default_nettype wire

// ==== sat_engine.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the DPLL engine for one bin; load all clause slots
// while idle, pulse start_i and wait for done_o
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module sat_engine
    import sat_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_we_i,
    input  logic [`SAT_CLS_W-1:0]    load_addr_i,
    input  clause_t                  load_clause_i,
    input  logic                     start_i,
    output logic                     done_o,
    output logic                     sat_o,
    output logic                     unsat_o,
    output logic [`SAT_NUM_VARS-1:0] model_o
);

    var_vec_t              vars;
    logic                  imp_we;
    logic [`SAT_VAR_W-1:0] imp_var;
    logic                  imp_val;
    logic                  dec_we;
    logic [`SAT_VAR_W-1:0] dec_var;
    logic                  bkt_we;
    logic [`SAT_VAR_W-1:0] bkt_var;
    logic [`SAT_LVL_W-1:0] bkt_lvl;
    logic                  apply_imply;
    logic                  done_imply;
    logic                  conflict;
    logic                  all_sat;
    logic                  start_decision;
    logic                  done_decision;
    logic                  apply_analyze;
    logic                  done_analyze;
    logic                  bkt_found;
    logic                  apply_bkt;
    logic                  done_bkt;
    logic                  busy_q;
    logic                  run;

    // an accepted start also empties the trail left by the previous run
    assign run = start_i && (!busy_q || done_o);

    always_ff @(posedge clk)
    begin
        if (!rst)
            busy_q <= 1'b0;
        else
            busy_q <= run || (busy_q && !done_o);
    end

    always_comb
    begin
        for (int i = 0; i < `SAT_NUM_VARS; i++)
            model_o[i] = vars[i].value;
    end

    sat_assign_store store_i (
        .clk       (clk),
        .rst       (rst),
        .imp_we_i  (imp_we),
        .imp_var_i (imp_var),
        .imp_val_i (imp_val),
        .dec_we_i  (dec_we),
        .dec_var_i (dec_var),
        .bkt_we_i  (bkt_we || run),
        .bkt_var_i (bkt_var),
        .bkt_lvl_i (run ? '0 : bkt_lvl),
        .vars_o    (vars),
        .cur_lvl_o ()
    );

    sat_imply imply_i (
        .clk           (clk),
        .rst           (rst),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_clause_i (load_clause_i),
        .apply_i       (apply_imply),
        .vars_i        (vars),
        .imp_we_o      (imp_we),
        .imp_var_o     (imp_var),
        .imp_val_o     (imp_val),
        .done_o        (done_imply),
        .conflict_o    (conflict),
        .all_sat_o     (all_sat)
    );

    sat_decide decide_i (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start_decision),
        .vars_i    (vars),
        .dec_we_o  (dec_we),
        .dec_var_o (dec_var),
        .done_o    (done_decision)
    );

    sat_backtrack backtrack_i (
        .clk             (clk),
        .rst             (rst),
        .apply_analyze_i (apply_analyze),
        .apply_bkt_i     (apply_bkt),
        .vars_i          (vars),
        .done_analyze_o  (done_analyze),
        .bkt_found_o     (bkt_found),
        .done_bkt_o      (done_bkt),
        .bkt_we_o        (bkt_we),
        .bkt_var_o       (bkt_var),
        .bkt_lvl_o       (bkt_lvl)
    );

    ctrl_core ctrl_i (
        .clk                 (clk),
        .rst                 (rst),
        .start_core_i        (run),
        .done_imply_i        (done_imply),
        .conflict_i          (conflict),
        .all_c_is_sat_i      (all_sat),
        .done_decision_i     (done_decision),
        .done_analyze_i      (done_analyze),
        .bkt_found_i         (bkt_found),
        .done_bkt_cur_bin_i  (done_bkt),
        .done_core_o         (done_o),
        .apply_imply_o       (apply_imply),
        .start_decision_o    (start_decision),
        .apply_analyze_o     (apply_analyze),
        .apply_bkt_cur_bin_o (apply_bkt),
        .sat_o               (sat_o),
        .unsat_o             (unsat_o)
    );

endmodule

`default_nettype wire

// ==== tb_sat_engine.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the DPLL engine, loads hand-written and random formulas,
// runs each one and checks the verdict and model against a brute-force search
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "sat_engine_cfg.svh"

module tb_sat_engine
    import sat_pkg::*;
();

    typedef clause_t [`SAT_NUM_CLAUSES-1:0] formula_t;

    localparam int TIMEOUT = 20000;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     load_we_i;
    logic [`SAT_CLS_W-1:0]    load_addr_i;
    clause_t                  load_clause_i;
    logic                     start_i;
    logic                     done_o;
    logic                     sat_o;
    logic                     unsat_o;
    logic [`SAT_NUM_VARS-1:0] model_o;

    formula_t formula;           // formula of the run in progress
    formula_t stim;
    logic     exp_sat;
    int       done_cnt = 0;
    int       runs     = 0;

    sat_engine dut_i (
        .clk           (clk),
        .rst           (rst),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_clause_i (load_clause_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .sat_o         (sat_o),
        .unsat_o       (unsat_o),
        .model_o       (model_o)
    );

    always #2 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // literal from a signed index, 0 disables it and a minus sign negates
    function automatic lit_t mk_lit(input int v);
        lit_t l;
        l = '0;
        if (v != 0)
        begin
            l.en      = 1'b1;
            l.neg     = v < 0;
            l.var_idx = `SAT_VAR_W'((v < 0 ? -v : v) - 1);
        end
        return l;
    endfunction

    function automatic clause_t mk_cls(input int v0, input int v1, input int v2);
        clause_t c;
        c.lit[0] = mk_lit(v0);
        c.lit[1] = mk_lit(v1);
        c.lit[2] = mk_lit(v2);
        return c;
    endfunction

    function automatic logic clause_holds(input clause_t c, input logic [`SAT_NUM_VARS-1:0] a);
        logic hit;
        logic act;
        hit = 1'b0;
        act = 1'b0;
        for (int k = 0; k < 3; k++)
        begin
            if (c.lit[k].en)
            begin
                act = 1'b1;
                if (a[c.lit[k].var_idx] != c.lit[k].neg)
                    hit = 1'b1;
            end
        end
        return hit || !act;   // a clause without literals counts as satisfied
    endfunction

    // tries every assignment of the variables
    function automatic logic ref_sat(input formula_t f);
        logic ok;
        for (int a = 0; a < (1 << `SAT_NUM_VARS); a++)
        begin
            ok = 1'b1;
            for (int j = 0; j < `SAT_NUM_CLAUSES; j++)
                ok = ok && clause_holds(f[j], `SAT_NUM_VARS'(a));
            if (ok)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic formula_t random_formula();
        formula_t f;
        f = '0;
        for (int j = 0; j < `SAT_NUM_CLAUSES; j++)
        begin
            if ($urandom_range(7) != 0)   // about one slot in eight stays empty
            begin
                for (int k = 0; k < 3; k++)
                begin
                    f[j].lit[k].en      = $urandom_range(3) != 0;
                    f[j].lit[k].neg     = 1'($urandom_range(1));
                    f[j].lit[k].var_idx = `SAT_VAR_W'($urandom_range(`SAT_NUM_VARS - 1));
                end
            end
        end
        return f;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_model(input logic [`SAT_NUM_VARS-1:0] model, input formula_t f);
        for (int j = 0; j < `SAT_NUM_CLAUSES; j++)
        begin
            if (!clause_holds(f[j], model))
                report_fail($sformatf("mismatch model_o: 0x%h leaves clause 0x%h false",
                                      model, j));
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare process, runs on the falling edge where outputs are stable
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk)
    begin
        if (rst)
        begin
            if (sat_o && unsat_o)
                report_fail("sat_o and unsat_o are high at the same time");
            if (done_o)
            begin
                done_cnt++;
                check_bit("sat_o", sat_o, exp_sat);
                check_bit("unsat_o", unsat_o, !exp_sat);
                if (exp_sat)
                    check_model(model_o, formula);
            end
        end
    end

    task automatic run_formula(input formula_t f);
        int cycles;
        formula = f;
        exp_sat = ref_sat(f);
        for (int a = 0; a < `SAT_NUM_CLAUSES; a++)   // every slot, the memory has no reset
        begin
            @(posedge clk);
            #1;
            load_we_i     = 1'b1;
            load_addr_i   = `SAT_CLS_W'(a);
            load_clause_i = f[a];
        end
        @(posedge clk);
        #1;
        load_we_i = 1'b0;
        start_i   = 1'b1;
        runs++;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        cycles  = 0;
        while (!done_o && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done_o)
            report_fail("timeout, done_o never came after start_i");
        repeat (3) @(posedge clk);
        #1;
        if (done_cnt != runs)
            report_fail($sformatf("mismatch done_o pulse count: got 0x%h expected 0x%h",
                                  done_cnt, runs));
    endtask

    initial
    begin
        rst           = 1'b0;
        load_we_i     = 1'b0;
        load_addr_i   = '0;
        load_clause_i = '0;
        start_i       = 1'b0;
        exp_sat       = 1'b0;
        formula       = '0;
        stim          = '0;
        void'($urandom(4759));
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (2) @(negedge clk);
        check_bit("done_o", done_o, 1'b0);
        check_bit("sat_o", sat_o, 1'b0);
        check_bit("unsat_o", unsat_o, 1'b0);

        // chain of units from x0 through x7
        stim    = '0;
        stim[0] = mk_cls(1, 0, 0);
        stim[1] = mk_cls(-1, 2, 0);
        stim[2] = mk_cls(-2, 3, 0);
        stim[3] = mk_cls(-3, -4, 0);
        stim[4] = mk_cls(4, 5, 0);
        stim[5] = mk_cls(-5, -6, 0);
        stim[6] = mk_cls(6, 7, 0);
        stim[7] = mk_cls(-7, 0, 8);
        check_bit("reference verdict", ref_sat(stim), 1'b1);
        run_formula(stim);

        stim = '0;
        for (int m = 0; m < 8; m++)
            stim[m] = mk_cls(m[0] ? -1 : 1, m[1] ? -2 : 2, m[2] ? -3 : 3);
        check_bit("reference verdict", ref_sat(stim), 1'b0);
        run_formula(stim);

        // x0 = 0 and later x2 = 0 both end in a conflict
        stim    = '0;
        stim[0] = mk_cls(1, 2, 0);
        stim[1] = mk_cls(1, -2, 0);
        stim[2] = mk_cls(-1, 3, 4);
        stim[3] = mk_cls(-3, -4, 0);
        stim[4] = mk_cls(-4, 3, 0);
        check_bit("reference verdict", ref_sat(stim), 1'b1);
        run_formula(stim);

        for (int n = 0; n < 200; n++)
            run_formula(random_formula());

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sat_engine.f ====
+incdir+.
sat_pkg.sv
sat_assign_store.sv
sat_imply.sv
sat_decide.sv
sat_backtrack.sv
ctrl_core.sv
sat_engine.sv
tb_sat_engine.sv

// ==== Bender.yml ====
package:
  name: sat_engine

export_include_dirs:
  - .

sources:
  - sat_pkg.sv
  - sat_assign_store.sv
  - sat_imply.sv
  - sat_decide.sv
  - sat_backtrack.sv
  - ctrl_core.sv
  - sat_engine.sv
  - target: simulation
    files:
      - tb_sat_engine.sv
